//--- design/addr_queue.sv
`timescale 1ns/1ps
`default_nettype none

module addr_queue import if_pkg::*; #(
    parameter int unsigned QUEUE_DEPTH = 2
) (
    input  logic         clk_i,
    input  logic         rst_ni,
    addr_queue_if.queue  aq,
    line_if.addr_src     line
);

    localparam int unsigned PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH + 1);

    // granted line addresses with the oldest at rd_ptr_q
    addr_t            mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
    logic [CNT_W-1:0] cnt_q;
    logic             do_push, do_pop;

    // wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign aq.empty = (cnt_q == '0);
    assign aq.full  = (cnt_q == CNT_W'(QUEUE_DEPTH));

    // push and pop together are both honoured
    assign do_push = aq.push && !aq.full;
    assign do_pop  = aq.pop && !aq.empty;

    assign aq.head_addr = mem[rd_ptr_q];
    // returned line is paired with the oldest request
    assign line.addr    = aq.head_addr;

    // ----------------------------
    // pointers and count
    // ----------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            if (do_push && !do_pop) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (do_pop && !do_push) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // address storage
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= aq.push_addr;
        end
    end

endmodule

`default_nettype wire

//--- design/fetch_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_buffer import if_pkg::*; #(
    parameter int unsigned BUF_DEPTH = 16
) (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    flush_i,
    line_if.buffer  line,
    // read port 0
    output logic    fetch_valid_0_o,
    output addr_t   fetch_addr_0_o,
    output instr_t  fetch_instr_0_o,
    output logic    fetch_inrange_0_o,
    input  logic    fetch_ack_0_i,
    // read port 1
    output logic    fetch_valid_1_o,
    output addr_t   fetch_addr_1_o,
    output instr_t  fetch_instr_1_o,
    output logic    fetch_inrange_1_o,
    input  logic    fetch_ack_1_i,
    // read port 2
    output logic    fetch_valid_2_o,
    output addr_t   fetch_addr_2_o,
    output instr_t  fetch_instr_2_o,
    output logic    fetch_inrange_2_o,
    input  logic    fetch_ack_2_i,
    // read port 3
    output logic    fetch_valid_3_o,
    output addr_t   fetch_addr_3_o,
    output instr_t  fetch_instr_3_o,
    output logic    fetch_inrange_3_o,
    input  logic    fetch_ack_3_i
);

    localparam int unsigned PTR_W = $clog2(BUF_DEPTH);
    localparam int unsigned CNT_W = PTR_W + 1;
    localparam int unsigned ACK_W = $clog2(LINE_WORDS + 1);
    localparam int unsigned WORD_W = $bits(instr_t);

    // entry storage
    addr_t  addr_mem    [BUF_DEPTH];
    instr_t instr_mem   [BUF_DEPTH];
    logic   inrange_mem [BUF_DEPTH];

    logic [PTR_W-1:0] rd_ptr_q, wr_ptr_q;
    logic [CNT_W-1:0] cnt_q;

    // write side, one entry per word of the line
    addr_t                 line_base;
    slot_t                 line_slot;
    addr_t                 wr_addr    [LINE_WORDS];
    instr_t                wr_instr   [LINE_WORDS];
    logic [LINE_WORDS-1:0] wr_inrange;

    // read side
    logic [LINE_WORDS-1:0] ack;
    logic [ACK_W-1:0]      n_ack;
    logic [LINE_WORDS-1:0] rd_valid;
    addr_t                 rd_addr    [LINE_WORDS];
    instr_t                rd_instr   [LINE_WORDS];
    logic [LINE_WORDS-1:0] rd_inrange;

    // keep room for the line possibly in flight plus one more
    assign line.ready = (cnt_q <= CNT_W'(BUF_DEPTH - 2 * LINE_WORDS));

    assign line_base = {line.addr[63:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};
    assign line_slot = line.addr[LINE_OFFSET_BITS-1 -: SLOT_BITS];

    // ----------------------------
    // line split
    // ----------------------------
    always_comb begin
        for (int k = 0; k < LINE_WORDS; k++) begin
            wr_addr[k]    = line_base + addr_t'(k * (WORD_W / 8));
            // lowest address word lives in the top bits
            wr_instr[k]   = line.rdata[(LINE_WORDS - 1 - k) * WORD_W +: WORD_W];
            // words before the start offset are out of range
            wr_inrange[k] = (slot_t'(k) >= line_slot);
        end
    end

    always_ff @(posedge clk_i) begin
        if (line.valid) begin
            for (int k = 0; k < LINE_WORDS; k++) begin
                addr_mem[wr_ptr_q + PTR_W'(k)]    <= wr_addr[k];
                instr_mem[wr_ptr_q + PTR_W'(k)]   <= wr_instr[k];
                inrange_mem[wr_ptr_q + PTR_W'(k)] <= wr_inrange[k];
            end
        end
    end

    // ----------------------------
    // read ports
    // ----------------------------
    assign ack = {fetch_ack_3_i, fetch_ack_2_i, fetch_ack_1_i, fetch_ack_0_i};

    always_comb begin
        // acks arrive in order, so a population count is enough
        n_ack = '0;
        for (int k = 0; k < LINE_WORDS; k++) begin
            n_ack         = n_ack + ACK_W'(ack[k]);
            rd_valid[k]   = (cnt_q > CNT_W'(k));
            rd_addr[k]    = addr_mem[rd_ptr_q + PTR_W'(k)];
            rd_instr[k]   = instr_mem[rd_ptr_q + PTR_W'(k)];
            rd_inrange[k] = inrange_mem[rd_ptr_q + PTR_W'(k)];
        end
    end

    assign fetch_valid_0_o   = rd_valid[0];
    assign fetch_addr_0_o    = rd_addr[0];
    assign fetch_instr_0_o   = rd_instr[0];
    assign fetch_inrange_0_o = rd_inrange[0];
    assign fetch_valid_1_o   = rd_valid[1];
    assign fetch_addr_1_o    = rd_addr[1];
    assign fetch_instr_1_o   = rd_instr[1];
    assign fetch_inrange_1_o = rd_inrange[1];
    assign fetch_valid_2_o   = rd_valid[2];
    assign fetch_addr_2_o    = rd_addr[2];
    assign fetch_instr_2_o   = rd_instr[2];
    assign fetch_inrange_2_o = rd_inrange[2];
    assign fetch_valid_3_o   = rd_valid[3];
    assign fetch_addr_3_o    = rd_addr[3];
    assign fetch_instr_3_o   = rd_instr[3];
    assign fetch_inrange_3_o = rd_inrange[3];

    // pointers and count, flush wins over any write
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_q + PTR_W'(n_ack);
            wr_ptr_q <= wr_ptr_q + (line.valid ? PTR_W'(LINE_WORDS) : '0);
            cnt_q    <= cnt_q - CNT_W'(n_ack) + (line.valid ? CNT_W'(LINE_WORDS) : '0);
        end
    end

endmodule

`default_nettype wire

//--- design/fetch_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// ----------------------------
// address queue handshake
// ----------------------------
interface addr_queue_if import if_pkg::*; ();
    // push on every granted request
    logic  push;
    addr_t push_addr;
    // pop on every rvalid, dropped ones included
    logic  pop;
    // oldest outstanding address
    addr_t head_addr;
    logic  empty;
    logic  full;

    modport requester (
        output push, push_addr, pop,
        input  empty, full
    );

    modport queue (
        input  push, push_addr, pop,
        output head_addr, empty, full
    );
endinterface

// ----------------------------
// returned line towards buffer
// ----------------------------
interface line_if import if_pkg::*; ();
    // rvalid, masked while aborting
    logic  valid;
    // address paired with the line, from the queue head
    addr_t addr;
    line_t rdata;
    // room for another line
    logic  ready;

    modport producer (output valid, input ready);
    modport addr_src (output addr);
    modport buffer   (input valid, addr, rdata, output ready);
endinterface

`default_nettype wire

//--- design/fetch_req_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_req_fsm import if_pkg::*; (
    input  logic   clk_i,
    input  logic   rst_ni,
    input  logic   flush_i,
    // PC generator side
    input  logic   fetch_valid_i,
    input  addr_t  fetch_address_i,
    output logic   if_busy_o,
    // instruction cache side
    output logic   instr_req_o,
    output addr_t  instr_addr_o,
    input  logic   instr_gnt_i,
    input  logic   instr_rvalid_i,
    // towards address queue and fetch buffer
    addr_queue_if.requester aq,
    line_if.producer        line
);

    fetch_state_e state_q, state_d;
    // address of the request still waiting for its grant
    addr_t        req_addr_q, req_addr_d;
    // full address of the request presented this cycle
    addr_t        cur_addr;
    logic         can_req;
    logic         line_valid;

    // room in both the buffer and the queue
    assign can_req = line.ready && !aq.full;

    // waiting for a grant or blocked by back-pressure, never while draining
    assign if_busy_o = ((state_q == WAIT_GNT) || (state_q == ABORT_PENDING) ||
                        !line.ready || aq.full) && (state_q != ABORT_DRAIN);

    // cache sees line aligned addresses only
    assign instr_addr_o = {cur_addr[63:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};

    // queue keeps the word offset for the in-range marking
    assign aq.push      = instr_req_o && instr_gnt_i;
    assign aq.push_addr = cur_addr;
    // every response frees its queue slot
    assign aq.pop       = instr_rvalid_i;
    assign line.valid   = line_valid;

    // ----------------------------
    // request FSM
    // ----------------------------
    always_comb begin
        state_d     = state_q;
        req_addr_d  = fetch_address_i;
        cur_addr    = fetch_address_i;
        instr_req_o = 1'b0;
        line_valid  = instr_rvalid_i;

        case (state_q)
            IDLE: begin
                if (fetch_valid_i && can_req) begin
                    instr_req_o = 1'b1;
                    state_d     = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;
                end
            end

            WAIT_GNT: begin
                // keep presenting the stalled request
                instr_req_o = 1'b1;
                cur_addr    = req_addr_q;
                req_addr_d  = req_addr_q;
                if (instr_gnt_i) begin
                    state_d = WAIT_RVALID;
                end
            end

            WAIT_RVALID: begin
                // next request may overlap the outstanding one
                if (fetch_valid_i && can_req) begin
                    instr_req_o = 1'b1;
                    state_d     = instr_gnt_i ? WAIT_RVALID : WAIT_GNT;
                end else begin
                    state_d = IDLE;
                end
            end

            ABORT_DRAIN: begin
                // responses of flushed requests are swallowed
                line_valid = 1'b0;
                if (fetch_valid_i) begin
                    // save the new address, reissue once the queue is clear
                    state_d = aq.empty ? WAIT_GNT : ABORT_PENDING;
                end else if (aq.empty) begin
                    state_d = IDLE;
                end
            end

            ABORT_PENDING: begin
                line_valid = 1'b0;
                req_addr_d = req_addr_q;
                if (aq.empty) begin
                    state_d = WAIT_GNT;
                end
            end

            default: begin
                state_d = IDLE;
            end
        endcase

        // ----------------------------
        // flush
        // ----------------------------
        if (flush_i) begin
            // nothing in flight and nothing granted now, so no drain needed
            if (aq.empty && !(instr_req_o && instr_gnt_i)) begin
                state_d = IDLE;
            end else begin
                state_d = ABORT_DRAIN;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            req_addr_q <= '0;
        end else begin
            state_q    <= state_d;
            req_addr_q <= req_addr_d;
        end
    end

endmodule

`default_nettype wire

//--- design/if_pkg.sv
`default_nettype none

package if_pkg;

    // ----------------------------
    // line geometry
    // ----------------------------
    // words per cache line, fixed by the four decoder read ports
    localparam int unsigned LINE_WORDS = 4;
    // byte offset bits below a line address
    localparam int unsigned LINE_OFFSET_BITS = 4;
    // word index bits inside a line
    localparam int unsigned SLOT_BITS = 2;

    // ----------------------------
    // data types
    // ----------------------------
    typedef logic [63:0]  addr_t;
    typedef logic [31:0]  instr_t;
    // word at the lowest address sits in the top 32 bits
    typedef logic [127:0] line_t;
    typedef logic [SLOT_BITS-1:0] slot_t;

    // request stage states
    typedef enum logic [2:0] {
        IDLE,
        WAIT_GNT,
        WAIT_RVALID,
        ABORT_DRAIN,
        ABORT_PENDING
    } fetch_state_e;

endpackage

`default_nettype wire

//--- design/if_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module if_stage_top import if_pkg::*; #(
    parameter int unsigned QUEUE_DEPTH = 2,
    parameter int unsigned BUF_DEPTH   = 16
) (
    input  logic   clk_i,
    input  logic   rst_ni,
    input  logic   flush_i,
    // PC generator
    input  logic   fetch_valid_i,
    input  addr_t  fetch_address_i,
    output logic   if_busy_o,
    // instruction cache
    output logic   instr_req_o,
    output addr_t  instr_addr_o,
    input  logic   instr_gnt_i,
    input  logic   instr_rvalid_i,
    input  line_t  instr_rdata_i,
    // decoder read ports
    output logic   fetch_valid_0_o,
    output logic   fetch_valid_1_o,
    output logic   fetch_valid_2_o,
    output logic   fetch_valid_3_o,
    output addr_t  fetch_addr_0_o,
    output addr_t  fetch_addr_1_o,
    output addr_t  fetch_addr_2_o,
    output addr_t  fetch_addr_3_o,
    output instr_t fetch_instr_0_o,
    output instr_t fetch_instr_1_o,
    output instr_t fetch_instr_2_o,
    output instr_t fetch_instr_3_o,
    output logic   fetch_inrange_0_o,
    output logic   fetch_inrange_1_o,
    output logic   fetch_inrange_2_o,
    output logic   fetch_inrange_3_o,
    input  logic   fetch_ack_0_i,
    input  logic   fetch_ack_1_i,
    input  logic   fetch_ack_2_i,
    input  logic   fetch_ack_3_i
);

    addr_queue_if aq_bus ();
    line_if       line_bus ();

    // cache data goes straight to the buffer
    assign line_bus.rdata = instr_rdata_i;

    // ----------------------------
    // request stage
    // ----------------------------
    fetch_req_fsm i_fetch_req_fsm (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .fetch_valid_i   (fetch_valid_i),
        .fetch_address_i (fetch_address_i),
        .if_busy_o       (if_busy_o),
        .instr_req_o     (instr_req_o),
        .instr_addr_o    (instr_addr_o),
        .instr_gnt_i     (instr_gnt_i),
        .instr_rvalid_i  (instr_rvalid_i),
        .aq              (aq_bus.requester),
        .line            (line_bus.producer)
    );

    // outstanding line addresses
    addr_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) i_addr_queue (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .aq     (aq_bus.queue),
        .line   (line_bus.addr_src)
    );

    // ----------------------------
    // four port fetch buffer
    // ----------------------------
    fetch_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) i_fetch_buffer (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .flush_i           (flush_i),
        .line              (line_bus.buffer),
        .fetch_valid_0_o   (fetch_valid_0_o),
        .fetch_addr_0_o    (fetch_addr_0_o),
        .fetch_instr_0_o   (fetch_instr_0_o),
        .fetch_inrange_0_o (fetch_inrange_0_o),
        .fetch_ack_0_i     (fetch_ack_0_i),
        .fetch_valid_1_o   (fetch_valid_1_o),
        .fetch_addr_1_o    (fetch_addr_1_o),
        .fetch_instr_1_o   (fetch_instr_1_o),
        .fetch_inrange_1_o (fetch_inrange_1_o),
        .fetch_ack_1_i     (fetch_ack_1_i),
        .fetch_valid_2_o   (fetch_valid_2_o),
        .fetch_addr_2_o    (fetch_addr_2_o),
        .fetch_instr_2_o   (fetch_instr_2_o),
        .fetch_inrange_2_o (fetch_inrange_2_o),
        .fetch_ack_2_i     (fetch_ack_2_i),
        .fetch_valid_3_o   (fetch_valid_3_o),
        .fetch_addr_3_o    (fetch_addr_3_o),
        .fetch_instr_3_o   (fetch_instr_3_o),
        .fetch_inrange_3_o (fetch_inrange_3_o),
        .fetch_ack_3_i     (fetch_ack_3_i)
    );

endmodule

`default_nettype wire

//--- if_stage_top.f
design/if_pkg.sv
design/fetch_ifs.sv
design/fetch_req_fsm.sv
design/addr_queue.sv
design/fetch_buffer.sv
design/if_stage_top.sv
verif/tb_if_stage.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_if_stage -f if_stage_top.f -o tb_if_stage
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/tb_if_stage)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

//--- verif/fetch_tests.txt
# columns: test name, operation, operand a in hex, operand b in decimal
# fetch a=address b=lines, ack a=ports per cycle (5 random), stall b=cycles, level b=entries, busy a=level b=cycles
aligned   ack   4    0
aligned   fetch 1000 4
aligned   drain 0    0
unaligned ack   2    0
unaligned fetch 2008 1
unaligned fetch 2114 1
unaligned fetch 222c 2
unaligned drain 0    0
fill      ack   0    0
fill      fetch 3000 4
fill      level 0    16
fill      busy  1    20
fill      stall 0    10
fill      ack   5    0
fill      drain 0    0
flush_one ack   0    0
flush_one fetch 4000 1
flush_one stall 0    2
flush_one flush 0    0
flush_one fetch 5004 2
flush_one ack   3    0
flush_one drain 0    0
flush_two ack   0    0
flush_two fetch 6000 2
flush_two stall 0    3
flush_two flush 0    0
flush_two fetch 700c 3
flush_two ack   1    0
flush_two drain 0    0
mixed     ack   5    0
mixed     fetch 8004 6
mixed     drain 0    0

//--- verif/tb_if_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_if_stage import if_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int BUF_ENTRIES  = 16;
    localparam int WATCH_CYCLES = 300;
    localparam int LEVEL_LIMIT  = 200;

    logic              clk_i;
    logic              rst_ni;
    logic              flush_i;
    logic              fetch_valid_i;
    addr_t             fetch_address_i;
    logic              if_busy_o;
    logic              instr_req_o;
    addr_t             instr_addr_o;
    logic              instr_gnt_i;
    logic              instr_rvalid_i;
    line_t             instr_rdata_i;
    // decoder side with the read port as index
    logic [3:0]        ack;
    logic [3:0]        port_valid;
    addr_t [3:0]       port_addr;
    instr_t [3:0]      port_instr;
    logic [3:0]        port_inrange;

    // test list from the data file
    string  t_name [$];
    string  t_op   [$];
    addr_t  t_a    [$];
    int     t_b    [$];
    int     n_ops;
    string  cur_test;

    // PC generator, cache and scoreboard state
    addr_t  pend      [$];
    addr_t  accepted  [$];
    addr_t  resp_addr [$];
    int     resp_due  [$];
    bit     resp_drop [$];
    addr_t  exp_addr  [$];
    instr_t exp_instr [$];
    logic   exp_inr   [$];
    int     cycle;
    int     gnt_wait;
    int     ack_w;
    logic   flush_req;

    if_stage_top dut0 (
        .clk_i (clk_i), .rst_ni (rst_ni), .flush_i (flush_i),
        .fetch_valid_i (fetch_valid_i), .fetch_address_i (fetch_address_i),
        .if_busy_o (if_busy_o), .instr_req_o (instr_req_o), .instr_addr_o (instr_addr_o),
        .instr_gnt_i (instr_gnt_i), .instr_rvalid_i (instr_rvalid_i),
        .instr_rdata_i (instr_rdata_i),
        .fetch_valid_0_o (port_valid[0]), .fetch_valid_1_o (port_valid[1]),
        .fetch_valid_2_o (port_valid[2]), .fetch_valid_3_o (port_valid[3]),
        .fetch_addr_0_o (port_addr[0]), .fetch_addr_1_o (port_addr[1]),
        .fetch_addr_2_o (port_addr[2]), .fetch_addr_3_o (port_addr[3]),
        .fetch_instr_0_o (port_instr[0]), .fetch_instr_1_o (port_instr[1]),
        .fetch_instr_2_o (port_instr[2]), .fetch_instr_3_o (port_instr[3]),
        .fetch_inrange_0_o (port_inrange[0]), .fetch_inrange_1_o (port_inrange[1]),
        .fetch_inrange_2_o (port_inrange[2]), .fetch_inrange_3_o (port_inrange[3]),
        .fetch_ack_0_i (ack[0]), .fetch_ack_1_i (ack[1]),
        .fetch_ack_2_i (ack[2]), .fetch_ack_3_i (ack[3])
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ------------------------------
    // reference model helpers
    // ------------------------------
    function automatic addr_t line_of(addr_t a);
        return {a[63:4], 4'h0};
    endfunction

    // word k of line L is the inverted low half of L + 4k
    function automatic instr_t cache_word(addr_t line_addr, int k);
        return ~(line_addr[31:0] + 32'(4 * k));
    endfunction

    // lowest address word goes to the top bits
    function automatic line_t cache_line(addr_t line_addr);
        line_t l;
        for (int k = 0; k < 4; k++) begin
            l[(3 - k) * 32 +: 32] = cache_word(line_addr, k);
        end
        return l;
    endfunction

    task automatic fail_now(string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_addr(string what, addr_t exp, addr_t act);
        if (act !== exp) begin
            fail_now($sformatf("FAILED %s %s expected %h actual %h", cur_test, what, exp, act));
        end
    endtask

    task automatic check_instr(string what, instr_t exp, instr_t act);
        if (act !== exp) begin
            fail_now($sformatf("FAILED %s %s expected %h actual %h", cur_test, what, exp, act));
        end
    endtask

    task automatic check_inrange(string what, logic exp, logic act);
        if (act !== exp) begin
            fail_now($sformatf("FAILED %s %s expected %b actual %b", cur_test, what, exp, act));
        end
    endtask

    // control outputs such as valid, busy and request
    task automatic check_flag(string what, logic exp, logic act);
        if (act !== exp) begin
            fail_now($sformatf("FAILED %s %s expected %b actual %b", cur_test, what, exp, act));
        end
    endtask

    // ------------------------------
    // drive all inputs on the falling edge
    // ------------------------------
    task automatic step();
        int w;
        @(negedge clk_i);
        // width 5 picks a random ack width each cycle
        w = (ack_w == 5) ? int'($urandom_range(0, 4)) : ack_w;
        for (int k = 0; k < 4; k++) begin
            ack[k] = (k < w) && port_valid[k];
        end
        flush_i         = flush_req;
        fetch_valid_i   = !flush_req && (pend.size() > 0) && !if_busy_o;
        fetch_address_i = (pend.size() > 0) ? pend[0] : '0;
        instr_gnt_i     = (gnt_wait == 0);
        if (resp_due.size() > 0 && resp_due[0] <= cycle) begin
            instr_rvalid_i = 1'b1;
            instr_rdata_i  = cache_line(line_of(resp_addr[0]));
        end else begin
            instr_rvalid_i = 1'b0;
            instr_rdata_i  = '0;
        end
    endtask

    // ------------------------------
    // monitor and scoreboard on the rising edge
    // ------------------------------
    always @(posedge clk_i) begin
        int n;
        int due;
        if (rst_ni) begin
            // ports against the scoreboard head before this edge
            for (int k = 0; k < 4; k++) begin
                check_flag($sformatf("valid %0d", k), exp_addr.size() > k, port_valid[k]);
                if (port_valid[k]) begin
                    check_addr($sformatf("addr %0d", k), exp_addr[k], port_addr[k]);
                    check_instr($sformatf("instr %0d", k), exp_instr[k], port_instr[k]);
                    check_inrange($sformatf("inrange %0d", k), exp_inr[k], port_inrange[k]);
                end
            end
            n = 0;
            for (int k = 0; k < 4; k++) begin
                if (ack[k]) begin
                    n++;
                end
            end
            repeat (n) begin
                void'(exp_addr.pop_front());
                void'(exp_instr.pop_front());
                void'(exp_inr.pop_front());
            end
            // fetch taken while busy is low
            if (fetch_valid_i && !if_busy_o && !flush_i) begin
                accepted.push_back(fetch_address_i);
                void'(pend.pop_front());
            end
            // on a grant schedule the in-order response
            if (instr_req_o && instr_gnt_i) begin
                if (accepted.size() == 0) begin
                    fail_now("a grant was seen for a request that was never accepted");
                end
                check_addr("request address", line_of(accepted[0]), instr_addr_o);
                due = cycle + int'($urandom_range(1, 4));
                if (resp_due.size() > 0 && due <= resp_due[$]) begin
                    due = resp_due[$] + 1;
                end
                resp_addr.push_back(accepted.pop_front());
                resp_due.push_back(due);
                resp_drop.push_back(1'b0);
                gnt_wait = int'($urandom_range(0, 2));
            end else if (instr_req_o && gnt_wait > 0) begin
                gnt_wait--;
            end
            // everything granted up to now is lost
            if (flush_i) begin
                exp_addr.delete();
                exp_instr.delete();
                exp_inr.delete();
                accepted.delete();
                foreach (resp_drop[i]) begin
                    resp_drop[i] = 1'b1;
                end
            end
            if (instr_rvalid_i) begin
                if (!resp_drop[0]) begin
                    for (int k = 0; k < 4; k++) begin
                        exp_addr.push_back(line_of(resp_addr[0]) + addr_t'(4 * k));
                        exp_instr.push_back(cache_word(line_of(resp_addr[0]), k));
                        exp_inr.push_back(k >= int'(resp_addr[0][3:2]));
                    end
                end
                void'(resp_addr.pop_front());
                void'(resp_due.pop_front());
                void'(resp_drop.pop_front());
            end
            if (exp_addr.size() > BUF_ENTRIES) begin
                fail_now("more entries were returned than the fetch buffer can hold");
            end
        end
        cycle++;
    end

    // watchdog scaled by the number of test lines
    initial begin
        wait (n_ops > 0);
        #(n_ops * WATCH_CYCLES * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d clock cycles", n_ops * WATCH_CYCLES);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int    fd;
        int    cnt;
        int    waited;
        string line_s;
        string name;
        string op;
        addr_t a;
        int    b;
        clk_i           = 1'b0;
        rst_ni          = 1'b0;
        flush_i         = 1'b0;
        fetch_valid_i   = 1'b0;
        fetch_address_i = '0;
        instr_gnt_i     = 1'b0;
        instr_rvalid_i  = 1'b0;
        instr_rdata_i   = '0;
        ack             = '0;
        ack_w           = 0;
        flush_req       = 1'b0;
        cycle           = 0;
        gnt_wait        = 0;
        n_ops           = 0;
        cur_test        = "reset";
        void'($urandom(31088));

        fd = $fopen("verif/fetch_tests.txt", "r");
        if (fd == 0) begin
            fail_now("could not open verif/fetch_tests.txt");
        end
        while (!$feof(fd)) begin
            line_s = "";
            if ($fgets(line_s, fd) > 0 && line_s.len() > 1 && line_s.substr(0, 0) != "#") begin
                cnt = $sscanf(line_s, "%s %s %h %d", name, op, a, b);
                if (cnt != 4) begin
                    fail_now($sformatf("badly formed test line: %s", line_s));
                end
                t_name.push_back(name);
                t_op.push_back(op);
                t_a.push_back(a);
                t_b.push_back(b);
            end
        end
        $fclose(fd);
        n_ops = t_op.size();

        // two cycles of reset
        repeat (2) step();
        rst_ni = 1'b1;
        check_flag("instr_req_o", 1'b0, instr_req_o);
        check_flag("if_busy_o", 1'b0, if_busy_o);
        for (int k = 0; k < 4; k++) begin
            check_flag($sformatf("valid %0d", k), 1'b0, port_valid[k]);
        end

        for (int i = 0; i < n_ops; i++) begin
            cur_test = t_name[i];
            case (t_op[i])
                "ack": begin
                    ack_w = int'(t_a[i]);
                end
                "fetch": begin
                    // first address as given and whole lines after it
                    for (int j = 0; j < t_b[i]; j++) begin
                        pend.push_back((j == 0) ? t_a[i] : line_of(t_a[i]) + addr_t'(16 * j));
                    end
                end
                "stall": begin
                    repeat (t_b[i]) step();
                end
                "flush": begin
                    pend.delete();
                    flush_req = 1'b1;
                    step();
                    flush_req = 1'b0;
                end
                "level": begin
                    waited = 0;
                    while (exp_addr.size() != t_b[i]) begin
                        if (waited == LEVEL_LIMIT) begin
                            fail_now($sformatf("%s: buffer never held %0d entries", cur_test, t_b[i]));
                        end
                        step();
                        waited++;
                    end
                end
                "busy": begin
                    waited = 0;
                    while (if_busy_o !== t_a[i][0]) begin
                        if (waited == t_b[i]) begin
                            fail_now($sformatf("%s: if_busy_o did not reach %0d in time", cur_test,
                                               t_a[i][0]));
                        end
                        step();
                        waited++;
                    end
                end
                "drain": begin
                    while (pend.size() > 0 || accepted.size() > 0 || resp_addr.size() > 0 ||
                           exp_addr.size() > 0) begin
                        step();
                    end
                end
                default: begin
                    fail_now($sformatf("unknown operation %s in test %s", t_op[i], cur_test));
                end
            endcase
        end
        step();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire
